/* source/dlc_cfg.svh */
`ifndef DLC_CFG_SVH
`define DLC_CFG_SVH

// Entries per FIFO, both sample and packet side
`define DLC_FIFO_DEPTH 4

// Incoming sample width, signed
`define DLC_SAMPLE_W 32

// Outgoing packet width, dt field over dlvl field
`define DLC_PKT_W 16

`endif

/* source/dlc_pkg.sv */
`include "dlc_cfg.svh"

package dlc_pkg;

  // Static configuration, replaces the register block
  typedef struct packed {
    logic [3:0]  discard;        // Low sample bits dropped
    logic [3:0]  log_wl;         // log2 of level width
    logic [3:0]  dlvl_bits;      // Width of delta-level field
    logic [15:0] dt_max;         // Delta-time saturation value
    logic        hysteresis_en;  // Suppress direction reversals
    logic [15:0] trans_size;     // Samples per transaction
  } dlc_cfg_t;

  typedef struct packed {
    logic                     push;
    logic [`DLC_SAMPLE_W-1:0] data;
  } sample_req_t;

  typedef struct packed {
    logic full;
    logic alm_full;  // One free entry left
  } sample_rsp_t;

  typedef struct packed {
    logic [`DLC_PKT_W-1:0] data;  // FIFO head
    logic                  empty;
  } pkt_rsp_t;

  // Detector result for the sample popped this cycle
  typedef struct packed {
    logic               valid;
    logic               xing;
    logic               dir;   // 1 for a downward move
    logic signed [15:0] dlvl;  // New level minus current level
  } xing_t;

  typedef enum logic {
    ENC_RUN,
    ENC_DT_OVF  // Waiting to emit a saturated dt packet
  } enc_state_t;

endpackage

/* source/dlc_fifo.sv */
`timescale 1ns/1ps
`include "dlc_cfg.svh"

module dlc_fifo #(
  parameter int WIDTH = `DLC_SAMPLE_W
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             alm_full_o,
  output logic             empty_o
);

  localparam int DEPTH = `DLC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] usage;
  logic             wr_en, rd_en;

  assign wr_en = push_i & ~full_o;   // Push on full is dropped
  assign rd_en = pop_i & ~empty_o;

  assign full_o     = (usage == CNT_W'(DEPTH));
  assign alm_full_o = (usage == CNT_W'(DEPTH - 1));
  assign empty_o    = (usage == '0);
  assign data_o     = mem[rd_ptr];  // Head, no fall-through

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      usage  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   usage <= usage + 1'b1;
        2'b01:   usage <= usage - 1'b1;
        default: usage <= usage;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Producers must respect full, consumers must respect empty
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o));

endmodule

/* source/dlc_crossing_detector.sv */
`timescale 1ns/1ps
`include "dlc_cfg.svh"

module dlc_crossing_detector
  import dlc_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dlc_cfg_t                 cfg_i,
  input  logic [`DLC_SAMPLE_W-1:0] sample_i,  // Sample FIFO head
  input  logic                     pop_i,     // Head consumed this cycle
  output xing_t                    res_o,
  output logic                     xing_o,
  output logic                     dir_o
);

  logic [`DLC_SAMPLE_W-1:0] sample_shr;
  logic signed [15:0]       sample_trim;
  logic signed [15:0]       din_lvl;
  logic signed [15:0]       curr_lvl;
  logic signed [15:0]       dlvl;
  logic                     dlvl_nz;
  logic                     dir;
  logic                     dir_d1;  // Sign of last nonzero dlvl
  logic                     xing;

  // Quantizer
  always_comb begin
    sample_shr  = sample_i >> cfg_i.discard;       // Drop noise bits
    sample_trim = $signed(sample_shr[15:0]);       // Keep 16 bits
    din_lvl     = sample_trim >>> cfg_i.log_wl;    // Sign-preserving
  end

  assign dlvl    = din_lvl - curr_lvl;
  assign dlvl_nz = pop_i && (dlvl != 16'sd0);
  assign dir     = dlvl[15];  // Negative delta means downward

  // With hysteresis a reversal only arms dir_d1 and emits no packet
  assign xing = dlvl_nz && (!cfg_i.hysteresis_en || (dir == dir_d1));

  always_comb begin
    res_o.valid = pop_i;
    res_o.xing  = xing;
    res_o.dir   = dir;
    res_o.dlvl  = dlvl;
  end

  // Current level and last direction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_lvl <= '0;
      dir_d1   <= 1'b0;
    end else begin
      if (xing) begin
        curr_lvl <= din_lvl;
      end
      if (dlvl_nz) begin
        dir_d1 <= dir;  // Tracks every nonzero move
      end
    end
  end

  // Registered strobes to the outside
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xing_o <= 1'b0;
      dir_o  <= 1'b0;
    end else begin
      xing_o <= xing;
      if (xing) begin
        dir_o <= dir;  // Holds last crossing direction
      end
    end
  end

  // A crossing needs a popped sample behind it
  a_xing_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_o.xing |-> res_o.valid);

endmodule

/* source/dlc_packet_encoder.sv */
`timescale 1ns/1ps
`include "dlc_cfg.svh"

module dlc_packet_encoder
  import dlc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dlc_cfg_t              cfg_i,
  input  logic                  in_empty_i,   // Sample FIFO empty
  input  logic                  out_full_i,   // Packet FIFO full
  input  xing_t                 res_i,
  output logic                  pop_o,
  output logic                  push_o,
  output logic [`DLC_PKT_W-1:0] pkt_o
);

  enc_state_t        state_q, state_d;
  logic [15:0]       dt_cnt;       // Samples since last packet
  logic [15:0]       dt_cnt_d;
  logic [15:0]       dlvl_mask;
  logic [15:0]       dt_val;
  logic [15:0]       dlvl_val;
  logic              no_xing;
  logic              dt_sat;
  logic              ovf_push;

  // Pop only when there is room for a possible packet
  assign pop_o = ~in_empty_i & ~out_full_i & (state_q == ENC_RUN);

  assign no_xing  = res_i.valid & ~res_i.xing;
  assign dt_sat   = no_xing & (dt_cnt == cfg_i.dt_max);
  assign ovf_push = (state_q == ENC_DT_OVF) & ~out_full_i;

  // Crossing only exists on a pop, which already saw room
  assign push_o = res_i.xing | ovf_push;

  always_comb begin
    state_d  = state_q;
    dt_cnt_d = dt_cnt;
    case (state_q)
      ENC_RUN: begin
        if (res_i.xing) begin
          dt_cnt_d = 16'd1;         // Restart after packet
        end else if (dt_sat) begin
          state_d = ENC_DT_OVF;     // Counter holds dt_max
        end else if (no_xing) begin
          dt_cnt_d = dt_cnt + 16'd1;
        end
      end
      ENC_DT_OVF: begin
        if (ovf_push) begin
          state_d  = ENC_RUN;
          dt_cnt_d = 16'd1;
        end
      end
      default: state_d = ENC_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ENC_RUN;
      dt_cnt  <= 16'd1;
    end else begin
      state_q <= state_d;
      dt_cnt  <= dt_cnt_d;
    end
  end

  // Packet formatting, dt above a dlvl_bits wide field
  always_comb begin
    dlvl_mask = (16'd1 << cfg_i.dlvl_bits) - 16'd1;
    dt_val    = (state_q == ENC_DT_OVF) ? cfg_i.dt_max : dt_cnt;
    dlvl_val  = (state_q == ENC_DT_OVF) ? 16'd0 : res_i.dlvl;  // Overflow carries no move
    pkt_o     = (dt_val << cfg_i.dlvl_bits) | (dlvl_val & dlvl_mask);  // Excess dlvl truncated
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_o && out_full_i));

  // Overflow state is sticky until its packet goes out
  a_ovf_exit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ENC_DT_OVF && !push_o) |=> (state_q == ENC_DT_OVF));

endmodule

/* source/dlc_top.sv */
`timescale 1ns/1ps
`include "dlc_cfg.svh"

module dlc_top
  import dlc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dlc_cfg_t    cfg_i,
  input  logic        flush_i,       // Loads the transaction counter
  input  sample_req_t sample_req_i,
  output sample_rsp_t sample_rsp_o,
  input  logic        pkt_pop_i,
  output pkt_rsp_t    pkt_rsp_o,
  output logic        done_o,
  output logic        xing_o,
  output logic        dir_o
);

  logic [`DLC_SAMPLE_W-1:0] smp_head;
  logic                     smp_empty;
  logic                     smp_pop;
  logic                     smp_push;     // Accepted push
  logic                     pkt_full;
  logic                     pkt_push;
  logic [`DLC_PKT_W-1:0]    pkt_data;
  xing_t                    res;
  logic [15:0]              trans_cnt;

  assign smp_push = sample_req_i.push & ~sample_rsp_o.full;  // Drop push on full

  dlc_fifo #(.WIDTH(`DLC_SAMPLE_W)) u_sample_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (smp_push),
    .data_i     (sample_req_i.data),
    .pop_i      (smp_pop),
    .data_o     (smp_head),
    .full_o     (sample_rsp_o.full),
    .alm_full_o (sample_rsp_o.alm_full),
    .empty_o    (smp_empty)
  );

  dlc_crossing_detector u_detector (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cfg_i    (cfg_i),
    .sample_i (smp_head),
    .pop_i    (smp_pop),
    .res_o    (res),
    .xing_o   (xing_o),
    .dir_o    (dir_o)
  );

  dlc_packet_encoder u_encoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg_i),
    .in_empty_i (smp_empty),
    .out_full_i (pkt_full),
    .res_i      (res),
    .pop_o      (smp_pop),
    .push_o     (pkt_push),
    .pkt_o      (pkt_data)
  );

  dlc_fifo #(.WIDTH(`DLC_PKT_W)) u_pkt_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (pkt_push),
    .data_i     (pkt_data),
    .pop_i      (pkt_pop_i),
    .data_o     (pkt_rsp_o.data),
    .full_o     (pkt_full),
    .alm_full_o (),              // Host only needs empty
    .empty_o    (pkt_rsp_o.empty)
  );

  // Transaction counter, done while zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trans_cnt <= '0;
    end else if (flush_i) begin
      trans_cnt <= cfg_i.trans_size;
    end else if (smp_push && (trans_cnt != '0)) begin
      trans_cnt <= trans_cnt - 16'd1;  // Saturates at zero
    end
  end

  assign done_o = (trans_cnt == '0);

endmodule

/* bench/dlc_checker.sv */
`timescale 1ns/1ps

module dlc_checker
  import dlc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dlc_cfg_t    cfg_i,
  input  logic        flush_i,
  input  sample_req_t sample_req_i,
  input  sample_rsp_t sample_rsp_i,
  input  logic        pkt_pop_i,
  input  pkt_rsp_t    pkt_rsp_i,
  input  logic        done_i,
  input  logic        xing_i,
  input  logic        dir_i
);

  logic [15:0] exp_q [$];  // Packets still owed by the DUT
  logic [15:0] exp_pkt;
  logic        dir_q [$];  // Directions of crossings still owed
  logic        exp_dir;
  logic [15:0] trans_m;    // Expected transaction count
  logic        full_q;     // Sample FIFO flags one cycle back
  logic        alm_q;
  logic        acc_q;      // Push accepted one cycle back
  int          err_cnt  = 0;
  int          err_base = 0;  // Errors before the current test
  int          n_pkts   = 0;
  int          n_tests  = 0;

  task automatic expect_pkt(input logic [15:0] pkt);
    exp_q.push_back(pkt);
  endtask

  task automatic queue_dir(input logic dir);
    dir_q.push_back(dir);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Every host pop must match the next owed packet
  always @(posedge clk_i) begin
    if (rst_ni && pkt_pop_i && !pkt_rsp_i.empty) begin
      n_pkts++;
      if (exp_q.size() == 0) begin
        $display("ERR %0t: unexpected packet %h", $time, pkt_rsp_i.data);
        err_cnt++;
      end else begin
        exp_pkt = exp_q.pop_front();
        if (pkt_rsp_i.data !== exp_pkt) begin
          $display("ERR %0t: packet %h, expected %h", $time, pkt_rsp_i.data, exp_pkt);
          err_cnt++;
        end
      end
    end
  end

  // Each crossing strobe carries the direction of its move
  always @(posedge clk_i) begin
    if (rst_ni && xing_i) begin
      if (dir_q.size() == 0) begin
        $display("ERR %0t: unexpected crossing strobe", $time);
        err_cnt++;
      end else begin
        exp_dir = dir_q.pop_front();
        if (dir_i !== exp_dir) begin
          $display("ERR %0t: dir_o is %b, expected %b", $time, dir_i, exp_dir);
          err_cnt++;
        end
      end
    end
  end

  // done must be high exactly while no accepted pushes are owed
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trans_m <= '0;
    end else begin
      if (done_i !== (trans_m == 16'd0)) begin
        $display("ERR %0t: done_o is %b with %0d pushes owed", $time, done_i, trans_m);
        err_cnt++;
      end
      if (flush_i) begin
        trans_m <= cfg_i.trans_size;
      end else if (sample_req_i.push && !sample_rsp_i.full && trans_m != 16'd0) begin
        trans_m <= trans_m - 16'd1;  // One accepted sample
      end
    end
  end

  // Sample FIFO moves by at most one entry per cycle
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      alm_q  <= 1'b0;
      acc_q  <= 1'b0;
    end else begin
      if (sample_rsp_i.full && sample_rsp_i.alm_full) begin
        $display("ERR %0t: sample FIFO full and almost full together", $time);
        err_cnt++;
      end
      if (sample_rsp_i.full && !(full_q || (alm_q && acc_q))) begin
        $display("ERR %0t: sample FIFO full without filling its last entry", $time);
        err_cnt++;
      end
      if ((full_q || (alm_q && acc_q)) && !(sample_rsp_i.full || sample_rsp_i.alm_full)) begin
        $display("ERR %0t: sample FIFO dropped below one free entry too fast", $time);
        err_cnt++;
      end
      full_q <= sample_rsp_i.full;
      alm_q  <= sample_rsp_i.alm_full;
      acc_q  <= sample_req_i.push && !sample_rsp_i.full;
    end
  end

  task automatic finish_test(input string name);
    int errs;
    if (exp_q.size() != 0) begin
      $display("Test %s: %0d expected packets never arrived", name, exp_q.size());
      err_cnt += exp_q.size();
      exp_q.delete();
    end
    if (dir_q.size() != 0) begin
      $display("Test %s: %0d crossing strobes never arrived", name, dir_q.size());
      err_cnt += dir_q.size();
      dir_q.delete();
    end
    errs = err_cnt - err_base;
    if (errs == 0) $display("Test %s: pass", name);
    else $display("Test %s: fail with %0d errors", name, errs);
    err_base = err_cnt;
    n_tests++;
  endtask

  task automatic report();
    $display("Tests %0d, packets popped %0d, errors %0d", n_tests, n_pkts, err_cnt);
  endtask

endmodule

/* bench/tb_dlc.sv */
`timescale 1ns/1ps

module tb_dlc
  import dlc_pkg::*;
();

  localparam int NT = 5;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  dlc_cfg_t    cfg_i;
  logic        flush_i;
  sample_req_t sample_req_i;
  sample_rsp_t sample_rsp_o;
  logic        pkt_pop_i;
  pkt_rsp_t    pkt_rsp_o;
  logic        done_o, xing, dir;
  logic        drain;       // Pop on every cycle
  int          cycles = 0;
  int          limit;
  int          off_s, off_e, off_x;  // Row offsets into the flat tables

  // Test table with one entry per row in each column
  string name_tab  [NT] = '{"ramp_up", "ramp_down", "hysteresis", "dt_overflow", "backpressure"};
  int    disc_tab  [NT] = '{0, 4, 0, 0, 0};
  int    lwl_tab   [NT] = '{2, 1, 0, 0, 0};
  int    bits_tab  [NT] = '{4, 3, 4, 4, 4};
  int    dtmax_tab [NT] = '{100, 100, 100, 3, 100};
  int    hyst_tab  [NT] = '{0, 0, 1, 0, 0};
  int    n_smp     [NT] = '{6, 5, 10, 9, 10};
  int    n_exp     [NT] = '{4, 4, 4, 4, 10};
  int    n_xing    [NT] = '{4, 4, 4, 2, 10};
  int    smp_tab   [40] = '{4, 8, 9, 16, 16, 20,
                            -32, -64, -64, 0, -200,
                            3, 2, 3, 4, 3, 2, 4, 6, 8, 10,  // Jitter then a steady rise
                            1, 1, 1, 1, 1, 1, 1, 1, 2,      // Flat past dt_max twice
                            1, 3, 6, 10, 15, 21, 28, 36, 30, 25};
  logic [15:0] exp_tab [26] = '{16'h0011, 16'h0011, 16'h0022, 16'h0021,
                                16'h000F, 16'h000F, 16'h0012, 16'h0009,  // Last dlvl truncated
                                16'h0013, 16'h0073, 16'h0012, 16'h0012,
                                16'h0011, 16'h0030, 16'h0030, 16'h0021,
                                16'h0011, 16'h0012, 16'h0013, 16'h0014, 16'h0015,
                                16'h0016, 16'h0017, 16'h0018, 16'h001A, 16'h001B};
  logic        dir_tab [24] = '{0, 0, 0, 0,
                                1, 1, 0, 1,  // Down, down, up, down
                                0, 0, 0, 0,
                                0, 0,        // Overflow packets carry no strobe
                                0, 0, 0, 0, 0, 0, 0, 0, 1, 1};

  always #20 clk_i = ~clk_i;  // 40 ns period

  dlc_top u_dut (
    .clk_i, .rst_ni, .cfg_i, .flush_i, .sample_req_i, .sample_rsp_o,
    .pkt_pop_i, .pkt_rsp_o, .done_o, .xing_o (xing), .dir_o (dir)
  );

  dlc_checker u_chk (
    .clk_i, .rst_ni, .cfg_i, .flush_i, .sample_req_i,
    .sample_rsp_i (sample_rsp_o), .pkt_pop_i, .pkt_rsp_i (pkt_rsp_o), .done_i (done_o),
    .xing_i (xing), .dir_i (dir)
  );

  // Host pops on random cycles to build back-pressure
  always @(posedge clk_i) begin
    #2;
    pkt_pop_i = !pkt_rsp_o.empty && (drain || ($urandom_range(0, 3) == 0));
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Run timed out after %0d cycles with packets still missing", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clk_i);
    #2 rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;
  endtask

  // Waits out a full FIFO and pushes for one cycle
  task automatic push_sample(input int value);
    while (sample_rsp_o.full) begin
      @(posedge clk_i);
      #2;
    end
    sample_req_i.push = 1'b1;
    sample_req_i.data = value;
    @(posedge clk_i);
    #2 sample_req_i.push = 1'b0;
  endtask

  initial begin
    void'($urandom(45384));
    rst_ni       = 1'b0;
    cfg_i        = '0;
    flush_i      = 1'b0;
    sample_req_i = '0;
    pkt_pop_i    = 1'b0;
    drain        = 1'b0;
    limit        = 200;
    for (int t = 0; t < NT; t++) limit += 16 * n_smp[t];
    off_s = 0;
    off_e = 0;
    off_x = 0;
    for (int t = 0; t < NT; t++) begin
      cfg_i.discard       = disc_tab[t];
      cfg_i.log_wl        = lwl_tab[t];
      cfg_i.dlvl_bits     = bits_tab[t];
      cfg_i.dt_max        = dtmax_tab[t];
      cfg_i.hysteresis_en = hyst_tab[t];
      cfg_i.trans_size    = n_smp[t];
      apply_reset();  // Level, direction and dt start fresh
      flush_i = 1'b1;
      @(posedge clk_i);
      #2 flush_i = 1'b0;
      for (int e = 0; e < n_exp[t]; e++) u_chk.expect_pkt(exp_tab[off_e + e]);
      for (int x = 0; x < n_xing[t]; x++) u_chk.queue_dir(dir_tab[off_x + x]);
      for (int s = 0; s < n_smp[t]; s++) push_sample(smp_tab[off_s + s]);
      do begin
        @(posedge clk_i);
        #2;
      end while (u_chk.pending() != 0);
      drain = 1'b1;  // Flush out any stray packet
      repeat (8) @(posedge clk_i);
      #2 drain = 1'b0;
      u_chk.finish_test(name_tab[t]);
      off_s += n_smp[t];
      off_e += n_exp[t];
      off_x += n_xing[t];
    end
    u_chk.report();
    if (u_chk.err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+source
source/dlc_pkg.sv
source/dlc_fifo.sv
source/dlc_crossing_detector.sv
source/dlc_packet_encoder.sv
source/dlc_top.sv
bench/dlc_checker.sv
bench/tb_dlc.sv
